// ==== rtl/obi_xbar_pkg.sv ====
/* OBI crossbar package with the bus widths, the bank count, the fixed address map
   and the request operation type */
package obi_xbar_pkg;

  localparam int unsigned NumMasters   = 2;
  localparam int unsigned NumBanks     = 2;
  localparam int unsigned BankIdxWidth = (NumBanks > 1) ? $clog2(NumBanks) : 1;
  localparam int unsigned MstIdxWidth  = (NumMasters > 1) ? $clog2(NumMasters) : 1;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned BeWidth   = DataWidth / 8;
  localparam int unsigned IdWidth   = 4;

  // Each bank covers BankWords words starting at its base byte address
  localparam int unsigned BankWords     = 256;
  localparam int unsigned BankBytes     = BankWords * BeWidth;
  localparam int unsigned WordAddrWidth = $clog2(BankWords);
  localparam int unsigned ByteOffset    = $clog2(BeWidth);
  localparam logic [NumBanks-1:0][AddrWidth-1:0] BankBase = {32'h0000_0400, 32'h0000_0000};

  // Outstanding limit per demux, also the depth of every mux route FIFO
  localparam int unsigned MaxTrans = 4;
  localparam int unsigned CntWidth = $clog2(MaxTrans + 1);
  localparam int unsigned PtrWidth = (MaxTrans > 1) ? $clog2(MaxTrans) : 1;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } obi_op_e;

endpackage

// ==== rtl/obi_addr_decode.sv ====
`timescale 1ns/1ps
/* Address decoder that maps a master address onto a bank index
   and flags addresses that fall outside every bank */
module obi_addr_decode (
  input  logic [obi_xbar_pkg::AddrWidth-1:0]    addr_i,
  output logic [obi_xbar_pkg::BankIdxWidth-1:0] idx_o,
  output logic                                  dec_error_o
);
  import obi_xbar_pkg::*;

  // Unmapped addresses fall back to index 0 with the error flag raised
  always_comb begin
    idx_o       = '0;
    dec_error_o = 1'b1;
    for (int unsigned b = 0; b < NumBanks; b++) begin
      if (addr_i >= BankBase[b] && addr_i < BankBase[b] + BankBytes) begin
        idx_o       = b[BankIdxWidth-1:0];
        dec_error_o = 1'b0;
      end
    end
  end

endmodule

// ==== rtl/obi_demux.sv ====
`timescale 1ns/1ps
/* OBI demultiplexer that steers one master onto a bank, keeps responses in order
   and answers unmapped addresses itself with an error */
module obi_demux (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  req_i,
  input  logic [obi_xbar_pkg::AddrWidth-1:0]    addr_i,
  input  obi_xbar_pkg::obi_op_e                 op_i,
  input  logic [obi_xbar_pkg::BeWidth-1:0]      be_i,
  input  logic [obi_xbar_pkg::DataWidth-1:0]    wdata_i,
  input  logic [obi_xbar_pkg::IdWidth-1:0]      aid_i,
  input  logic [obi_xbar_pkg::BankIdxWidth-1:0] select_i,
  input  logic                                  dec_error_i,
  output logic                                  gnt_o,
  output logic                                  rvalid_o,
  output logic [obi_xbar_pkg::DataWidth-1:0]    rdata_o,
  output logic                                  err_o,
  output logic [obi_xbar_pkg::IdWidth-1:0]      rid_o,

  output logic [obi_xbar_pkg::NumBanks-1:0]                              bank_req_o,
  output logic [obi_xbar_pkg::NumBanks-1:0][obi_xbar_pkg::AddrWidth-1:0] bank_addr_o,
  output obi_xbar_pkg::obi_op_e [obi_xbar_pkg::NumBanks-1:0]             bank_op_o,
  output logic [obi_xbar_pkg::NumBanks-1:0][obi_xbar_pkg::BeWidth-1:0]   bank_be_o,
  output logic [obi_xbar_pkg::NumBanks-1:0][obi_xbar_pkg::DataWidth-1:0] bank_wdata_o,
  output logic [obi_xbar_pkg::NumBanks-1:0][obi_xbar_pkg::IdWidth-1:0]   bank_aid_o,
  input  logic [obi_xbar_pkg::NumBanks-1:0]                              bank_gnt_i,
  input  logic [obi_xbar_pkg::NumBanks-1:0]                              bank_rvalid_i,
  input  logic [obi_xbar_pkg::NumBanks-1:0][obi_xbar_pkg::DataWidth-1:0] bank_rdata_i,
  input  logic [obi_xbar_pkg::NumBanks-1:0]                              bank_err_i,
  input  logic [obi_xbar_pkg::NumBanks-1:0][obi_xbar_pkg::IdWidth-1:0]   bank_rid_i
);
  import obi_xbar_pkg::*;

  logic [CntWidth-1:0]     cnt_q;
  logic [BankIdxWidth-1:0] tgt_idx_q;
  logic                    tgt_err_q;
  logic                    err_valid_q;
  logic [IdWidth-1:0]      err_rid_q;
  logic                    same_tgt;
  logic                    can_issue;
  logic                    accept;

  // A new target is only allowed once everything in flight has returned
  assign same_tgt  = (cnt_q == '0) ||
                     (tgt_err_q ? dec_error_i : (!dec_error_i && tgt_idx_q == select_i));
  assign can_issue = same_tgt && (cnt_q != CntWidth'(MaxTrans));

  always_comb begin
    for (int unsigned b = 0; b < NumBanks; b++) begin
      bank_req_o[b]   = req_i && can_issue && !dec_error_i && (select_i == b);
      bank_addr_o[b]  = addr_i;
      bank_op_o[b]    = op_i;
      bank_be_o[b]    = be_i;
      bank_wdata_o[b] = wdata_i;
      bank_aid_o[b]   = aid_i;
    end
  end

  // The local error responder takes every unmapped request straight away
  assign gnt_o  = req_i && can_issue && (dec_error_i || bank_gnt_i[select_i]);
  assign accept = req_i && gnt_o;

  // Only the locked target can have a response pending
  assign rvalid_o = tgt_err_q ? err_valid_q : bank_rvalid_i[tgt_idx_q];
  assign rdata_o  = tgt_err_q ? '0 : bank_rdata_i[tgt_idx_q];
  assign err_o    = tgt_err_q || bank_err_i[tgt_idx_q];
  assign rid_o    = tgt_err_q ? err_rid_q : bank_rid_i[tgt_idx_q];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q       <= '0;
      tgt_idx_q   <= '0;
      tgt_err_q   <= 1'b0;
      err_valid_q <= 1'b0;
    end else begin
      cnt_q       <= cnt_q + CntWidth'(accept) - CntWidth'(rvalid_o);
      err_valid_q <= accept && dec_error_i;
      if (accept) begin
        tgt_idx_q <= select_i;
        tgt_err_q <= dec_error_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && dec_error_i) begin
      err_rid_q <= aid_i;
    end
  end

  a_cnt_limit: assert property (@(posedge clk_i) disable iff (reset_i)
    cnt_q <= CntWidth'(MaxTrans));
  a_no_stray_rvalid: assert property (@(posedge clk_i) disable iff (reset_i)
    rvalid_o |-> cnt_q != '0);

endmodule

// ==== rtl/obi_mux.sv ====
`timescale 1ns/1ps
/* OBI multiplexer in front of one bank that arbitrates the masters round robin
   and sends each response back to the master that issued the request */
module obi_mux (
  input  logic clk_i,
  input  logic reset_i,

  input  logic [obi_xbar_pkg::NumMasters-1:0]                              req_i,
  input  logic [obi_xbar_pkg::NumMasters-1:0][obi_xbar_pkg::AddrWidth-1:0] addr_i,
  input  obi_xbar_pkg::obi_op_e [obi_xbar_pkg::NumMasters-1:0]             op_i,
  input  logic [obi_xbar_pkg::NumMasters-1:0][obi_xbar_pkg::BeWidth-1:0]   be_i,
  input  logic [obi_xbar_pkg::NumMasters-1:0][obi_xbar_pkg::DataWidth-1:0] wdata_i,
  input  logic [obi_xbar_pkg::NumMasters-1:0][obi_xbar_pkg::IdWidth-1:0]   aid_i,
  output logic [obi_xbar_pkg::NumMasters-1:0]                              gnt_o,
  output logic [obi_xbar_pkg::NumMasters-1:0]                              rvalid_o,
  output logic [obi_xbar_pkg::NumMasters-1:0][obi_xbar_pkg::DataWidth-1:0] rdata_o,
  output logic [obi_xbar_pkg::NumMasters-1:0]                              err_o,
  output logic [obi_xbar_pkg::NumMasters-1:0][obi_xbar_pkg::IdWidth-1:0]   rid_o,

  output logic                               bank_req_o,
  output logic [obi_xbar_pkg::AddrWidth-1:0] bank_addr_o,
  output obi_xbar_pkg::obi_op_e              bank_op_o,
  output logic [obi_xbar_pkg::BeWidth-1:0]   bank_be_o,
  output logic [obi_xbar_pkg::DataWidth-1:0] bank_wdata_o,
  output logic [obi_xbar_pkg::IdWidth-1:0]   bank_aid_o,
  input  logic                               bank_gnt_i,
  input  logic                               bank_rvalid_i,
  input  logic [obi_xbar_pkg::DataWidth-1:0] bank_rdata_i,
  input  logic                               bank_err_i,
  input  logic [obi_xbar_pkg::IdWidth-1:0]   bank_rid_i
);
  import obi_xbar_pkg::*;

  logic [MstIdxWidth-1:0] sel;
  logic [MstIdxWidth-1:0] rr_q;
  logic                   accept;
  logic [MstIdxWidth-1:0] fifo_mem [MaxTrans];
  logic [PtrWidth-1:0]    wr_ptr_q;
  logic [PtrWidth-1:0]    rd_ptr_q;
  logic [CntWidth-1:0]    fifo_cnt_q;
  logic                   fifo_full;
  logic                   fifo_empty;

  // Scan downwards so the requester closest to the pointer wins
  always_comb begin
    int unsigned cand;
    sel = rr_q;
    for (int k = NumMasters - 1; k >= 0; k--) begin
      cand = (int'(rr_q) + k) % NumMasters;
      if (req_i[cand]) begin
        sel = cand[MstIdxWidth-1:0];
      end
    end
  end

  assign fifo_full  = (fifo_cnt_q == CntWidth'(MaxTrans));
  assign fifo_empty = (fifo_cnt_q == '0);

  // Requests are held back while no route entry is free
  assign bank_req_o   = (|req_i) && !fifo_full;
  assign bank_addr_o  = addr_i[sel];
  assign bank_op_o    = op_i[sel];
  assign bank_be_o    = be_i[sel];
  assign bank_wdata_o = wdata_i[sel];
  assign bank_aid_o   = aid_i[sel];
  assign accept       = bank_req_o && bank_gnt_i;

  // The head of the route FIFO names the master owed the current response
  always_comb begin
    for (int unsigned m = 0; m < NumMasters; m++) begin
      gnt_o[m]    = accept && (sel == m);
      rvalid_o[m] = bank_rvalid_i && (fifo_mem[rd_ptr_q] == m);
      rdata_o[m]  = bank_rdata_i;
      err_o[m]    = bank_err_i;
      rid_o[m]    = bank_rid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_q       <= '0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
    end else begin
      fifo_cnt_q <= fifo_cnt_q + CntWidth'(accept) - CntWidth'(bank_rvalid_i);
      if (accept) begin
        rr_q     <= MstIdxWidth'((int'(sel) + 1) % NumMasters);
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(MaxTrans - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (bank_rvalid_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(MaxTrans - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      fifo_mem[wr_ptr_q] <= sel;
    end
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
    fifo_cnt_q <= CntWidth'(MaxTrans));
  a_no_rvalid_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    bank_rvalid_i |-> !fifo_empty);

endmodule

// ==== rtl/obi_xbar.sv ====
`timescale 1ns/1ps
/* OBI crossbar with a decoder and demux per master and a round-robin mux per bank */
module obi_xbar (
  input  logic clk_i,
  input  logic reset_i,

  input  logic [obi_xbar_pkg::NumMasters-1:0]                              m_req_i,
  input  logic [obi_xbar_pkg::NumMasters-1:0][obi_xbar_pkg::AddrWidth-1:0] m_addr_i,
  input  obi_xbar_pkg::obi_op_e [obi_xbar_pkg::NumMasters-1:0]             m_op_i,
  input  logic [obi_xbar_pkg::NumMasters-1:0][obi_xbar_pkg::BeWidth-1:0]   m_be_i,
  input  logic [obi_xbar_pkg::NumMasters-1:0][obi_xbar_pkg::DataWidth-1:0] m_wdata_i,
  input  logic [obi_xbar_pkg::NumMasters-1:0][obi_xbar_pkg::IdWidth-1:0]   m_aid_i,
  output logic [obi_xbar_pkg::NumMasters-1:0]                              m_gnt_o,
  output logic [obi_xbar_pkg::NumMasters-1:0]                              m_rvalid_o,
  output logic [obi_xbar_pkg::NumMasters-1:0][obi_xbar_pkg::DataWidth-1:0] m_rdata_o,
  output logic [obi_xbar_pkg::NumMasters-1:0]                              m_err_o,
  output logic [obi_xbar_pkg::NumMasters-1:0][obi_xbar_pkg::IdWidth-1:0]   m_rid_o,

  output logic [obi_xbar_pkg::NumBanks-1:0]                              b_req_o,
  output logic [obi_xbar_pkg::NumBanks-1:0][obi_xbar_pkg::AddrWidth-1:0] b_addr_o,
  output obi_xbar_pkg::obi_op_e [obi_xbar_pkg::NumBanks-1:0]             b_op_o,
  output logic [obi_xbar_pkg::NumBanks-1:0][obi_xbar_pkg::BeWidth-1:0]   b_be_o,
  output logic [obi_xbar_pkg::NumBanks-1:0][obi_xbar_pkg::DataWidth-1:0] b_wdata_o,
  output logic [obi_xbar_pkg::NumBanks-1:0][obi_xbar_pkg::IdWidth-1:0]   b_aid_o,
  input  logic [obi_xbar_pkg::NumBanks-1:0]                              b_gnt_i,
  input  logic [obi_xbar_pkg::NumBanks-1:0]                              b_rvalid_i,
  input  logic [obi_xbar_pkg::NumBanks-1:0][obi_xbar_pkg::DataWidth-1:0] b_rdata_i,
  input  logic [obi_xbar_pkg::NumBanks-1:0]                              b_err_i,
  input  logic [obi_xbar_pkg::NumBanks-1:0][obi_xbar_pkg::IdWidth-1:0]   b_rid_i
);
  import obi_xbar_pkg::*;

  logic [NumMasters-1:0][BankIdxWidth-1:0] select;
  logic [NumMasters-1:0]                   dec_error;

  // Demux side is indexed master first, mux side bank first
  logic    [NumMasters-1:0][NumBanks-1:0]                dm_req, dm_gnt, dm_rvalid, dm_err;
  logic    [NumMasters-1:0][NumBanks-1:0][AddrWidth-1:0] dm_addr;
  obi_op_e [NumMasters-1:0][NumBanks-1:0]                dm_op;
  logic    [NumMasters-1:0][NumBanks-1:0][BeWidth-1:0]   dm_be;
  logic    [NumMasters-1:0][NumBanks-1:0][DataWidth-1:0] dm_wdata, dm_rdata;
  logic    [NumMasters-1:0][NumBanks-1:0][IdWidth-1:0]   dm_aid, dm_rid;

  logic    [NumBanks-1:0][NumMasters-1:0]                mx_req, mx_gnt, mx_rvalid, mx_err;
  logic    [NumBanks-1:0][NumMasters-1:0][AddrWidth-1:0] mx_addr;
  obi_op_e [NumBanks-1:0][NumMasters-1:0]                mx_op;
  logic    [NumBanks-1:0][NumMasters-1:0][BeWidth-1:0]   mx_be;
  logic    [NumBanks-1:0][NumMasters-1:0][DataWidth-1:0] mx_wdata, mx_rdata;
  logic    [NumBanks-1:0][NumMasters-1:0][IdWidth-1:0]   mx_aid, mx_rid;

  for (genvar m = 0; m < NumMasters; m++) begin : g_master
    obi_addr_decode i_addr_decode (
      .addr_i      ( m_addr_i[m]  ),
      .idx_o       ( select[m]    ),
      .dec_error_o ( dec_error[m] )
    );

    obi_demux i_demux (
      .clk_i, .reset_i,
      .req_i ( m_req_i[m] ), .addr_i ( m_addr_i[m] ), .op_i ( m_op_i[m] ),
      .be_i ( m_be_i[m] ), .wdata_i ( m_wdata_i[m] ), .aid_i ( m_aid_i[m] ),
      .select_i ( select[m] ), .dec_error_i ( dec_error[m] ),
      .gnt_o ( m_gnt_o[m] ), .rvalid_o ( m_rvalid_o[m] ), .rdata_o ( m_rdata_o[m] ),
      .err_o ( m_err_o[m] ), .rid_o ( m_rid_o[m] ),
      .bank_req_o ( dm_req[m] ), .bank_addr_o ( dm_addr[m] ), .bank_op_o ( dm_op[m] ),
      .bank_be_o ( dm_be[m] ), .bank_wdata_o ( dm_wdata[m] ), .bank_aid_o ( dm_aid[m] ),
      .bank_gnt_i ( dm_gnt[m] ), .bank_rvalid_i ( dm_rvalid[m] ),
      .bank_rdata_i ( dm_rdata[m] ), .bank_err_i ( dm_err[m] ), .bank_rid_i ( dm_rid[m] )
    );

    for (genvar b = 0; b < NumBanks; b++) begin : g_transpose
      assign mx_req[b][m]    = dm_req[m][b];
      assign mx_addr[b][m]   = dm_addr[m][b];
      assign mx_op[b][m]     = dm_op[m][b];
      assign mx_be[b][m]     = dm_be[m][b];
      assign mx_wdata[b][m]  = dm_wdata[m][b];
      assign mx_aid[b][m]    = dm_aid[m][b];
      assign dm_gnt[m][b]    = mx_gnt[b][m];
      assign dm_rvalid[m][b] = mx_rvalid[b][m];
      assign dm_rdata[m][b]  = mx_rdata[b][m];
      assign dm_err[m][b]    = mx_err[b][m];
      assign dm_rid[m][b]    = mx_rid[b][m];
    end
  end

  for (genvar b = 0; b < NumBanks; b++) begin : g_bank
    obi_mux i_mux (
      .clk_i, .reset_i,
      .req_i ( mx_req[b] ), .addr_i ( mx_addr[b] ), .op_i ( mx_op[b] ),
      .be_i ( mx_be[b] ), .wdata_i ( mx_wdata[b] ), .aid_i ( mx_aid[b] ),
      .gnt_o ( mx_gnt[b] ), .rvalid_o ( mx_rvalid[b] ), .rdata_o ( mx_rdata[b] ),
      .err_o ( mx_err[b] ), .rid_o ( mx_rid[b] ),
      .bank_req_o ( b_req_o[b] ), .bank_addr_o ( b_addr_o[b] ), .bank_op_o ( b_op_o[b] ),
      .bank_be_o ( b_be_o[b] ), .bank_wdata_o ( b_wdata_o[b] ), .bank_aid_o ( b_aid_o[b] ),
      .bank_gnt_i ( b_gnt_i[b] ), .bank_rvalid_i ( b_rvalid_i[b] ),
      .bank_rdata_i ( b_rdata_i[b] ), .bank_err_i ( b_err_i[b] ), .bank_rid_i ( b_rid_i[b] )
    );
  end

endmodule

// ==== rtl/obi_sram_bank.sv ====
`timescale 1ns/1ps
/* Single-port SRAM bank with byte enables that answers every request one cycle later */
module obi_sram_bank (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  logic                               req_i,
  input  logic [obi_xbar_pkg::AddrWidth-1:0] addr_i,
  input  obi_xbar_pkg::obi_op_e              op_i,
  input  logic [obi_xbar_pkg::BeWidth-1:0]   be_i,
  input  logic [obi_xbar_pkg::DataWidth-1:0] wdata_i,
  input  logic [obi_xbar_pkg::IdWidth-1:0]   aid_i,
  output logic                               gnt_o,
  output logic                               rvalid_o,
  output logic [obi_xbar_pkg::DataWidth-1:0] rdata_o,
  output logic                               err_o,
  output logic [obi_xbar_pkg::IdWidth-1:0]   rid_o
);
  import obi_xbar_pkg::*;

  logic [DataWidth-1:0]     mem_q [BankWords];
  logic [WordAddrWidth-1:0] word_idx;

  // The bank never stalls
  assign gnt_o    = req_i;
  assign err_o    = 1'b0;
  // Upper address bits wrap since the decoder has already placed the access in this bank
  assign word_idx = addr_i[ByteOffset +: WordAddrWidth];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= mem_q[word_idx];
      rid_o   <= aid_i;
      if (op_i == OP_WRITE) begin
        for (int unsigned i = 0; i < BeWidth; i++) begin
          if (be_i[i]) begin
            mem_q[word_idx][8*i +: 8] <= wdata_i[8*i +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i;
    end
  end

endmodule

// ==== rtl/obi_mem_subsys.sv ====
`timescale 1ns/1ps
/* Memory subsystem top with two OBI masters sharing two SRAM banks via the crossbar */
module obi_mem_subsys (
  input  logic clk_i,
  input  logic reset_i,

  input  logic [obi_xbar_pkg::NumMasters-1:0]                              m_req_i,
  input  logic [obi_xbar_pkg::NumMasters-1:0][obi_xbar_pkg::AddrWidth-1:0] m_addr_i,
  input  obi_xbar_pkg::obi_op_e [obi_xbar_pkg::NumMasters-1:0]             m_op_i,
  input  logic [obi_xbar_pkg::NumMasters-1:0][obi_xbar_pkg::BeWidth-1:0]   m_be_i,
  input  logic [obi_xbar_pkg::NumMasters-1:0][obi_xbar_pkg::DataWidth-1:0] m_wdata_i,
  input  logic [obi_xbar_pkg::NumMasters-1:0][obi_xbar_pkg::IdWidth-1:0]   m_aid_i,
  output logic [obi_xbar_pkg::NumMasters-1:0]                              m_gnt_o,
  output logic [obi_xbar_pkg::NumMasters-1:0]                              m_rvalid_o,
  output logic [obi_xbar_pkg::NumMasters-1:0][obi_xbar_pkg::DataWidth-1:0] m_rdata_o,
  output logic [obi_xbar_pkg::NumMasters-1:0]                              m_err_o,
  output logic [obi_xbar_pkg::NumMasters-1:0][obi_xbar_pkg::IdWidth-1:0]   m_rid_o
);
  import obi_xbar_pkg::*;

  logic    [NumBanks-1:0]                b_req, b_gnt, b_rvalid, b_err;
  logic    [NumBanks-1:0][AddrWidth-1:0] b_addr;
  obi_op_e [NumBanks-1:0]                b_op;
  logic    [NumBanks-1:0][BeWidth-1:0]   b_be;
  logic    [NumBanks-1:0][DataWidth-1:0] b_wdata, b_rdata;
  logic    [NumBanks-1:0][IdWidth-1:0]   b_aid, b_rid;

  obi_xbar i_obi_xbar (
    .clk_i, .reset_i,
    .m_req_i, .m_addr_i, .m_op_i, .m_be_i, .m_wdata_i, .m_aid_i,
    .m_gnt_o, .m_rvalid_o, .m_rdata_o, .m_err_o, .m_rid_o,
    .b_req_o ( b_req ), .b_addr_o ( b_addr ), .b_op_o ( b_op ),
    .b_be_o ( b_be ), .b_wdata_o ( b_wdata ), .b_aid_o ( b_aid ),
    .b_gnt_i ( b_gnt ), .b_rvalid_i ( b_rvalid ), .b_rdata_i ( b_rdata ),
    .b_err_i ( b_err ), .b_rid_i ( b_rid )
  );

  for (genvar b = 0; b < NumBanks; b++) begin : g_bank
    obi_sram_bank i_sram_bank (
      .clk_i, .reset_i,
      .req_i ( b_req[b] ), .addr_i ( b_addr[b] ), .op_i ( b_op[b] ),
      .be_i ( b_be[b] ), .wdata_i ( b_wdata[b] ), .aid_i ( b_aid[b] ),
      .gnt_o ( b_gnt[b] ), .rvalid_o ( b_rvalid[b] ), .rdata_o ( b_rdata[b] ),
      .err_o ( b_err[b] ), .rid_o ( b_rid[b] )
    );
  end

endmodule

// ==== verification/tb_obi_mem_subsys.sv ====
`timescale 1ns/1ps
/* Testbench for the OBI memory subsystem with a reference memory model,
   round-robin checks and per-master response ordering */
module tb_obi_mem_subsys;
  import obi_xbar_pkg::*;

  localparam int ArbN          = 8;
  localparam int RandN         = 200;
  localparam int TotalTxn      = NumMasters * (ArbN + 2 * BankWords + 2 * RandN);
  localparam int TimeoutCycles = TotalTxn * 20 + 100;

  typedef struct packed {
    logic                 rd;
    logic [DataWidth-1:0] data;
    logic                 err;
    logic [IdWidth-1:0]   id;
  } exp_t;

  logic                                  clk_i;
  logic                                  reset_i;
  logic [NumMasters-1:0]                 m_req_i, m_gnt_o, m_rvalid_o, m_err_o;
  logic [NumMasters-1:0][AddrWidth-1:0]  m_addr_i;
  obi_op_e [NumMasters-1:0]              m_op_i;
  logic [NumMasters-1:0][BeWidth-1:0]    m_be_i;
  logic [NumMasters-1:0][DataWidth-1:0]  m_wdata_i, m_rdata_o;
  logic [NumMasters-1:0][IdWidth-1:0]    m_aid_i, m_rid_o;

  logic [DataWidth-1:0] model_mem [NumBanks][BankWords];
  exp_t                 exp_q [NumMasters][$];
  logic [IdWidth-1:0]   next_id [NumMasters];
  logic [31:0]          rng [NumMasters];
  logic [31:0]          seed;
  logic                 arb_check;
  logic                 arb_turn;

  obi_mem_subsys i_obi_mem_subsys (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift(inout logic [31:0] s);
    s ^= s << 13;
    s ^= s >> 17;
    s ^= s << 5;
    return s;
  endfunction

  function automatic logic [DataWidth-1:0] fill_word(input logic [AddrWidth-1:0] addr);
    return (addr * 32'h9E37_79B1) ^ (addr << 7) ^ 32'h5A5A_0F0F;
  endfunction

  // Expected response of one accepted request, updating the model memory on writes
  function automatic logic [DataWidth-1:0] ref_access(
      input logic [AddrWidth-1:0] addr, input obi_op_e op, input logic [BeWidth-1:0] be,
      input logic [DataWidth-1:0] wdata, output logic err);
    logic [DataWidth-1:0] old;
    int unsigned          word;
    int                   bank;
    bank = -1;
    word = 0;
    for (int b = 0; b < NumBanks; b++) begin
      if (addr >= BankBase[b] && addr < BankBase[b] + BankWords * 4) begin
        bank = b;
        word = (addr - BankBase[b]) / 4;
      end
    end
    err = (bank < 0);
    if (err) return '0;
    old = model_mem[bank][word];
    if (op == OP_WRITE) begin
      for (int i = 0; i < BeWidth; i++) begin
        if (be[i]) model_mem[bank][word][8*i +: 8] = wdata[8*i +: 8];
      end
    end
    return old;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic compare_data(input string name, input logic [DataWidth-1:0] got, exp);
    if (got !== exp) begin
      report_failure($sformatf("** Error at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic compare_flag(input string name, input logic got, exp);
    if (got !== exp) begin
      report_failure($sformatf("** Error at %0t: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic compare_id(input string name, input logic [IdWidth-1:0] got, exp);
    if (got !== exp) begin
      report_failure($sformatf("** Error at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  // Fields stay put until the grant is seen and the next edge accepts the request
  task automatic issue(input int m, input logic [AddrWidth-1:0] addr, input obi_op_e op,
                       input logic [BeWidth-1:0] be, input logic [DataWidth-1:0] wdata);
    @(posedge clk_i);
    m_req_i[m]   <= 1'b1;
    m_addr_i[m]  <= addr;
    m_op_i[m]    <= op;
    m_be_i[m]    <= be;
    m_wdata_i[m] <= wdata;
    m_aid_i[m]   <= next_id[m];
    next_id[m]   = next_id[m] + 1'b1;
    do begin
      @(negedge clk_i);
    end while (!m_gnt_o[m]);
  endtask

  task automatic idle(input int m);
    @(posedge clk_i);
    m_req_i[m] <= 1'b0;
  endtask

  task automatic run_arbitration(input int m);
    for (int k = 0; k < ArbN; k++) begin
      issue(m, BankBase[0] + AddrWidth'(8 * k + 4 * m), OP_WRITE, 4'hF, xorshift(rng[m]));
    end
    idle(m);
  endtask

  task automatic preload(input int m);
    logic [AddrWidth-1:0] addr;
    for (int w = 0; w < BankWords; w++) begin
      addr = BankBase[m] + AddrWidth'(4 * w);
      issue(m, addr, OP_WRITE, 4'hF, fill_word(addr));
    end
    idle(m);
  endtask

  task automatic random_traffic(input int m);
    logic [31:0]          r;
    logic [31:0]          d;
    logic [AddrWidth-1:0] addr;
    obi_op_e              op;
    for (int i = 0; i < RandN; i++) begin
      r = xorshift(rng[m]);
      d = xorshift(rng[m]);
      // About one address in sixteen lies above both banks
      if (r[3:0] == 4'h0) addr = {r[31:12], 1'b1, r[10:2], 2'b00};
      else addr = {21'h0, r[10:2], 2'b00};
      op = r[5] ? OP_WRITE : OP_READ;
      issue(m, addr, op, r[27:24], d);
      // Reading a written word straight back returns the merged value
      if (op == OP_WRITE) issue(m, addr, OP_READ, 4'h0, 32'h0);
    end
    idle(m);
  endtask

  task automatic readback(input int m);
    for (int w = 0; w < BankWords; w++) begin
      issue(m, BankBase[NumBanks-1-m] + AddrWidth'(4 * w), OP_READ, 4'h0, 32'h0);
    end
    idle(m);
  endtask

  // Responses are checked first, then the requests accepted at the coming edge are recorded
  always @(negedge clk_i) begin
    exp_t e;
    logic exp_err;
    for (int m = 0; m < NumMasters; m++) begin
      if (m_rvalid_o[m]) begin
        if (exp_q[m].size() == 0) begin
          report_failure($sformatf("Master %0d got a response with nothing outstanding", m));
        end else begin
          e = exp_q[m].pop_front();
          if (e.rd) compare_data($sformatf("m_rdata_o[%0d]", m), m_rdata_o[m], e.data);
          compare_flag($sformatf("m_err_o[%0d]", m), m_err_o[m], e.err);
          compare_id($sformatf("m_rid_o[%0d]", m), m_rid_o[m], e.id);
        end
      end else if (exp_q[m].size() != 0) begin
        report_failure($sformatf("Master %0d had no response in the cycle after acceptance", m));
      end
    end
    if (arb_check && (&m_req_i)) begin
      compare_flag("m_gnt_o[0]", m_gnt_o[0], arb_turn == 1'b0);
      compare_flag("m_gnt_o[1]", m_gnt_o[1], arb_turn == 1'b1);
      arb_turn = !arb_turn;
    end
    for (int m = 0; m < NumMasters; m++) begin
      if (m_req_i[m] && m_gnt_o[m]) begin
        e.data = ref_access(m_addr_i[m], m_op_i[m], m_be_i[m], m_wdata_i[m], exp_err);
        e.err  = exp_err;
        e.id   = m_aid_i[m];
        e.rd   = (m_op_i[m] == OP_READ) || exp_err;
        exp_q[m].push_back(e);
      end
    end
  end

  initial begin
    repeat (TimeoutCycles) @(posedge clk_i);
    report_failure("Timeout: the test did not complete in the expected number of cycles");
  end

  initial begin
    reset_i   = 1'b1;
    m_req_i   = '0;
    m_addr_i  = '0;
    m_be_i    = '0;
    m_wdata_i = '0;
    m_aid_i   = '0;
    arb_check = 1'b0;
    arb_turn  = 1'b0;
    seed      = 32'd75;
    for (int m = 0; m < NumMasters; m++) begin
      m_op_i[m]  = OP_READ;
      next_id[m] = '0;
      rng[m]     = xorshift(seed);
    end
    for (int b = 0; b < NumBanks; b++) begin
      for (int w = 0; w < BankWords; w++) model_mem[b][w] = '0;
    end
    repeat (3) @(posedge clk_i);
    reset_i   <= 1'b0;
    arb_check = 1'b1;
    repeat (2) begin
      @(negedge clk_i);
      for (int m = 0; m < NumMasters; m++) begin
        compare_flag($sformatf("m_rvalid_o[%0d]", m), m_rvalid_o[m], 1'b0);
      end
    end
    // Both masters contend for bank 0 while the arbiter pointers are still at reset
    fork
      run_arbitration(0);
      run_arbitration(1);
    join
    arb_check = 1'b0;
    fork
      preload(0);
      preload(1);
    join
    fork
      random_traffic(0);
      random_traffic(1);
    join
    fork
      readback(0);
      readback(1);
    join
    repeat (3) @(posedge clk_i);
    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== build.f ====
rtl/obi_xbar_pkg.sv
rtl/obi_addr_decode.sv
rtl/obi_demux.sv
rtl/obi_mux.sv
rtl/obi_xbar.sv
rtl/obi_sram_bank.sv
rtl/obi_mem_subsys.sv
verification/tb_obi_mem_subsys.sv

// ==== Bender.yml ====
package:
  name: obi_mem_subsys

sources:
  - files:
      - rtl/obi_xbar_pkg.sv
      - rtl/obi_addr_decode.sv
      - rtl/obi_demux.sv
      - rtl/obi_mux.sv
      - rtl/obi_xbar.sv
      - rtl/obi_sram_bank.sv
      - rtl/obi_mem_subsys.sv
  - target: test
    files:
      - verification/tb_obi_mem_subsys.sv
